//--- hdl/pad_pkg.sv
// ================================================
// Joypad port shared definitions
// Host pad words, mouse reports, console port
// control lines and the port mode bits
// ================================================

package pad_pkg;

	// ================================================
	// Defaults for the top level
	// ================================================
	localparam int DEFAULT_NUM_PADS           = 5;
	localparam int DEFAULT_MOUSE_TIMEOUT_BITS = 15;

	// ================================================
	// Host side inputs
	// ================================================

	// One host pad word, 1 = pressed
	typedef struct packed {
		logic btn_vi;   // Bit 11
		logic btn_v;
		logic btn_iv;
		logic btn_iii;  // Bit 8
		logic run;      // Bit 7
		logic select;
		logic btn_ii;
		logic btn_i;    // Bit 4
		logic up;       // Bit 3
		logic down;
		logic left;
		logic right;    // Bit 0
	} pad_buttons_t;

	// One word per multitap slot
	typedef pad_buttons_t pad_array_t [0:DEFAULT_NUM_PADS-1];

	// Host mouse report, a new report toggles stb
	typedef struct packed {
		logic       stb;
		logic       btn_left;
		logic       btn_right;
		logic [7:0] dx;  // Two's complement
		logic [7:0] dy;
	} mouse_report_t;

	// ================================================
	// Console side
	// ================================================
	typedef struct packed {
		logic clr;
		logic sel;
	} port_ctrl_t;

	typedef struct packed {
		logic multitap;    // Turbo Tap scan
		logic six_button;  // Bank toggle on CLR
		logic mouse;       // Mouse on port 0
	} port_mode_t;

	// Mouse nibble order within one read
	typedef enum logic [1:0] {
		PH_X_HIGH = 2'd0,
		PH_X_LOW  = 2'd1,
		PH_Y_HIGH = 2'd2,
		PH_Y_LOW  = 2'd3
	} mouse_phase_t;

	typedef logic [2:0] port_index_t;

endpackage

//--- hdl/mouse_tracker.sv
// ================================================
// Mouse tracker
// Captures host mouse reports and steps through
// the four motion nibbles on each CLR rise
// ================================================
`timescale 1ns/10ps

module mouse_tracker #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pad_pkg::mouse_report_t mouse,
	input  pad_pkg::port_ctrl_t    ctrl,
	output logic [3:0]             motion_nibble,
	output logic [1:0]             mouse_btn
);
	import pad_pkg::*;

	logic                          stb_prev;
	logic                          clr_prev;
	logic                          new_report;
	logic                          clr_rise;
	logic                          idle_expired;
	logic [7:0]                    pend_x;
	logic [7:0]                    pend_y;
	logic [7:0]                    shown_x;
	logic [7:0]                    shown_y;
	mouse_phase_t                  phase;
	logic [MOUSE_TIMEOUT_BITS-1:0] idle_cnt;  // Cycles with CLR low

	assign new_report   = mouse.stb ^ stb_prev;
	assign clr_rise     = ctrl.clr & ~clr_prev;
	assign idle_expired = &idle_cnt;

	function automatic mouse_phase_t next_phase(input mouse_phase_t ph);
		case (ph)
			PH_X_HIGH: return PH_X_LOW;
			PH_X_LOW:  return PH_Y_HIGH;
			PH_Y_HIGH: return PH_Y_LOW;
			default:   return PH_X_HIGH;
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stb_prev  <= 1'b0;
			clr_prev  <= 1'b0;
			pend_x    <= 8'd0;
			pend_y    <= 8'd0;
			shown_x   <= 8'd0;
			shown_y   <= 8'd0;
			mouse_btn <= 2'b00;
			phase     <= PH_Y_LOW;
			idle_cnt  <= '0;
		end else begin
			stb_prev <= mouse.stb;
			clr_prev <= ctrl.clr;

			// Saturating idle counter
			if (ctrl.clr)
				idle_cnt <= '0;
			else if (!idle_expired)
				idle_cnt <= idle_cnt + 1'b1;

			// Console gave up mid read, next CLR starts over
			if (idle_expired)
				phase <= PH_Y_LOW;

			if (clr_rise) begin
				phase <= next_phase(phase);
				if (phase == PH_Y_LOW) begin  // Start of a new read
					shown_x <= pend_x;
					shown_y <= pend_y;
					pend_x  <= 8'd0;
					pend_y  <= 8'd0;
				end
			end

			// Latest report wins, also over the clear above
			if (new_report) begin
				pend_x    <= 8'd0 - mouse.dx;  // Console X runs the other way
				pend_y    <= mouse.dy;
				mouse_btn <= {mouse.btn_left, mouse.btn_right};
			end
		end
	end

	always_comb begin
		case (phase)
			PH_X_HIGH: motion_nibble = shown_x[7:4];
			PH_X_LOW:  motion_nibble = shown_x[3:0];
			PH_Y_HIGH: motion_nibble = shown_y[7:4];
			default:   motion_nibble = shown_y[3:0];
		endcase
	end

endmodule

//--- hdl/port_scan.sv
// ================================================
// Port scan
// Follows CLR and SEL from the console, keeps the
// multitap slot index and the six-button bank
// ================================================
`timescale 1ns/10ps

module port_scan (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  pad_pkg::port_ctrl_t  ctrl,
	input  pad_pkg::port_mode_t  mode,
	output pad_pkg::port_index_t port_index,
	output logic                 high_bank
);

	logic clr_prev;
	logic sel_prev;
	logic clr_rise;
	logic sel_rise;

	// Edges against last cycle's levels
	assign clr_rise = ctrl.clr & ~clr_prev;
	assign sel_rise = ctrl.sel & ~sel_prev;

	// ================================================
	// Slot index and bank
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_prev   <= 1'b0;
			sel_prev   <= 1'b0;
			port_index <= '0;
			high_bank  <= 1'b0;
		end else begin
			clr_prev <= ctrl.clr;
			sel_prev <= ctrl.sel;

			if (ctrl.clr) begin
				port_index <= '0;  // Scan restarts at slot 0

				// Six-button pads swap banks every read cycle
				if (clr_rise)
					high_bank <= ~high_bank & mode.six_button;
			end else if (sel_rise && mode.multitap) begin
				port_index <= port_index + 3'd1;  // Next tap slot
			end
		end
	end

	// Without the tap the index never leaves slot 0;
	// the console just sees the same pad on every SEL
	// rise. An index past the last pad reads idle
	// downstream, which is how software detects the
	// number of tap slots.

endmodule

//--- hdl/nibble_drive.sv
// ================================================
// Nibble drive
// Builds the active-low port word for the current
// slot and latches the nibble the console reads
// ================================================
`timescale 1ns/10ps

module nibble_drive #(
	parameter int NUM_PADS = 5
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  pad_pkg::pad_array_t  pads,
	input  logic                 mouse_en,
	input  logic                 clr,
	input  logic                 sel,
	input  pad_pkg::port_index_t port_index,
	input  logic                 high_bank,
	input  logic [3:0]           motion_nibble,
	input  logic [1:0]           mouse_btn,
	output logic [3:0]           nibble
);
	import pad_pkg::*;

	localparam logic [15:0] IDLE_WORD = 16'h0FFF;  // Empty tap slot

	pad_buttons_t pad0;
	logic [7:0]   mouse_byte;
	logic [15:0]  port_word;
	logic [3:0]   sel_nibble;

	// Four nibbles by (bank, sel), low to high
	function automatic logic [15:0] pad_word(input pad_buttons_t p);
		return ~{4'hF,
			p.btn_vi, p.btn_v, p.btn_iv, p.btn_iii,
			p.left, p.down, p.right, p.up,
			p.run, p.select, p.btn_ii, p.btn_i};
	endfunction

	assign pad0 = pads[0];

	// Run and Select still come from pad 0 in mouse mode
	assign mouse_byte = {motion_nibble, ~{pad0.run, pad0.select, mouse_btn}};

	always_comb begin
		if (int'(port_index) >= NUM_PADS)
			port_word = IDLE_WORD;
		else if (mouse_en && port_index == 3'd0)
			port_word = {mouse_byte, mouse_byte};  // Same in both banks
		else
			port_word = pad_word(pads[port_index]);
	end

	assign sel_nibble = port_word[{high_bank, sel, 2'b00} +: 4];

	// ================================================
	// Output latch
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			nibble <= 4'h0;
		else if (clr)
			nibble <= 4'h0;  // Port reads 0 during CLR
		else
			nibble <= sel_nibble;
	end

endmodule

//--- hdl/pad_port_top.sv
// ================================================
// Joypad port top level
// Console pad port with Turbo Tap, six-button
// bank and mouse, fed by host pad and mouse input
// ================================================
`timescale 1ns/10ps

module pad_port_top #(
	parameter int NUM_PADS           = pad_pkg::DEFAULT_NUM_PADS,
	parameter int MOUSE_TIMEOUT_BITS = pad_pkg::DEFAULT_MOUSE_TIMEOUT_BITS
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pad_pkg::pad_array_t    pads,
	input  pad_pkg::mouse_report_t mouse,
	input  pad_pkg::port_ctrl_t    ctrl,
	input  pad_pkg::port_mode_t    mode,
	output logic [3:0]             nibble
);
	import pad_pkg::*;

	logic [3:0]  motion_nibble;
	logic [1:0]  mouse_btn;
	port_index_t port_index;
	logic        high_bank;

	// Mouse report capture and phase sequencing
	mouse_tracker #(
		.MOUSE_TIMEOUT_BITS(MOUSE_TIMEOUT_BITS)
	) u_mouse_tracker (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mouse         (mouse),
		.ctrl          (ctrl),
		.motion_nibble (motion_nibble),
		.mouse_btn     (mouse_btn)
	);

	// Tap slot and bank from CLR/SEL
	port_scan u_port_scan (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ctrl       (ctrl),
		.mode       (mode),
		.port_index (port_index),
		.high_bank  (high_bank)
	);

	nibble_drive #(
		.NUM_PADS(NUM_PADS)
	) u_nibble_drive (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pads          (pads),
		.mouse_en      (mode.mouse),
		.clr           (ctrl.clr),
		.sel           (ctrl.sel),
		.port_index    (port_index),
		.high_bank     (high_bank),
		.motion_nibble (motion_nibble),
		.mouse_btn     (mouse_btn),
		.nibble        (nibble)
	);

endmodule

//--- verif/pad_port_asserts.sv
// ================================================
// Joypad port assertions
// CLR and SEL protocol checks on the top level
// ================================================
`timescale 1ns/10ps

module pad_port_asserts (
	input logic                 clk_sys,
	input logic                 reset,
	input pad_pkg::port_ctrl_t  ctrl,
	input pad_pkg::port_mode_t  mode,
	input pad_pkg::port_index_t port_index,
	input logic [3:0]           nibble
);

	// Output latch clears once CLR is seen
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ctrl.clr) |=> nibble == 4'h0)
		else $error("nibble not 0 after CLR rise");

	// Scan restarts at slot 0
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ctrl.clr) |=> port_index == 3'd0)
		else $error("port index not 0 after CLR rise");

	assert property (@(posedge clk_sys) disable iff (reset)
		(!mode.multitap && !ctrl.clr) |=> $stable(port_index))  // No tap, no stepping
		else $error("port index moved with multitap off");

endmodule

bind pad_port_top pad_port_asserts u_pad_port_asserts (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.ctrl       (ctrl),
	.mode       (mode),
	.port_index (port_index),
	.nibble     (nibble)
);

//--- verif/tb_pad_port.sv
// ================================================
// Joypad port testbench
// Directed tests for pad mapping, Turbo Tap scan,
// six-button bank and mouse read-out
// ================================================
`timescale 1ns/10ps

module tb_pad_port;
	import pad_pkg::*;

	localparam int NUM_PADS    = 5;
	localparam int CYCLE_LIMIT = 20000;  // Tests need about 1300 cycles

	logic          clk_sys;
	logic          reset;
	pad_array_t    pads;
	mouse_report_t mouse;
	port_ctrl_t    ctrl;
	port_mode_t    mode;
	logic [3:0]    nibble;

	integer     seed;
	int         errors;
	int         checks;
	int         cycles = 0;
	logic       exp_bank;   // Bank the console should see
	int         exp_phase;  // Mouse nibble position where 3 is Y low
	logic [7:0] pend_x;
	logic [7:0] pend_y;
	logic [7:0] shown_x;
	logic [7:0] shown_y;
	logic [1:0] exp_btn;    // {left, right} of the last report

	pad_port_top #(
		.NUM_PADS           (NUM_PADS),
		.MOUSE_TIMEOUT_BITS (8)
	) DUT (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pads    (pads),
		.mouse   (mouse),
		.ctrl    (ctrl),
		.mode    (mode),
		.nibble  (nibble)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ================================================
	// Reference model of the port rules
	// ================================================
	function automatic logic [3:0] expected_nibble(input int idx, input logic sel);
		logic [11:0] w;
		w = pads[0];
		if (idx >= NUM_PADS)
			return (exp_bank && sel) ? 4'h0 : 4'hF;  // Empty tap slot
		if (mode.mouse && idx == 0) begin
			if (!sel)
				return ~{w[7], w[6], exp_btn};
			case (exp_phase)
				0:       return shown_x[7:4];
				1:       return shown_x[3:0];
				2:       return shown_y[7:4];
				default: return shown_y[3:0];
			endcase
		end
		w = pads[idx];
		case ({exp_bank, sel})
			2'b00:   return ~w[7:4];
			2'b01:   return ~{w[1], w[2], w[0], w[3]};  // Left, down, right, up
			2'b10:   return ~w[11:8];
			default: return 4'h0;
		endcase
	endfunction

	// ================================================
	// Drive and check helpers starting on a falling edge
	// ================================================
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic drive_ctrl(input logic clr, input logic sel);
		ctrl.clr = clr;
		ctrl.sel = sel;
		wait_cycles(3);
	endtask

	task automatic check_nibble(input logic [3:0] exp, input string what);
		checks++;
		if (nibble !== exp) begin
			errors++;
			$display("Fail at %0t: %s, expected %h, got %h", $time, what, exp, nibble);
		end
	endtask

	task automatic clr_pulse(input logic sel);
		drive_ctrl(1'b1, sel);
		check_nibble(4'h0, "nibble while CLR high");
		exp_bank = mode.six_button ? ~exp_bank : 1'b0;
		if (exp_phase == 3) begin  // New mouse read starts
			shown_x = pend_x;
			shown_y = pend_y;
			pend_x  = 8'd0;
			pend_y  = 8'd0;
		end
		exp_phase = (exp_phase + 1) % 4;
		drive_ctrl(1'b0, sel);
	endtask

	task automatic read_slot(input int idx, input string tag);
		drive_ctrl(1'b0, 1'b1);
		check_nibble(expected_nibble(idx, 1'b1), $sformatf("%s slot %0d sel 1", tag, idx));
		drive_ctrl(1'b0, 1'b0);
		check_nibble(expected_nibble(idx, 1'b0), $sformatf("%s slot %0d sel 0", tag, idx));
	endtask

	task automatic send_report(input logic [7:0] dx, input logic [7:0] dy,
		input logic bl, input logic br);
		mouse.dx        = dx;
		mouse.dy        = dy;
		mouse.btn_left  = bl;
		mouse.btn_right = br;
		mouse.stb       = ~mouse.stb;
		wait_cycles(2);
		pend_x  = ~dx + 8'd1;  // X is negated on the console side
		pend_y  = dy;
		exp_btn = {bl, br};
	endtask

	// Leave CLR low past the mouse timeout
	task automatic park_idle();
		ctrl.clr = 1'b0;
		wait_cycles(300);
		exp_phase = 3;
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic single_pad_mapping();
		int i;
		mode = '0;
		clr_pulse(1'b0);
		for (i = 0; i < 8; i++) begin
			pads[0] = pad_buttons_t'(12'($random(seed)));
			read_slot(0, "single pad");
			clr_pulse(1'b0);
		end
	endtask

	task automatic multitap_scan();
		int i;
		mode          = '0;
		mode.multitap = 1'b1;
		for (i = 0; i < NUM_PADS; i++)
			pads[i] = pad_buttons_t'(12'($random(seed)));
		clr_pulse(1'b1);  // SEL stays high so slot 0 reads first
		for (i = 0; i <= NUM_PADS; i++)
			read_slot(i, "multitap");
	endtask

	task automatic six_button_bank();
		int i;
		mode            = '0;
		mode.six_button = 1'b1;
		pads[0]         = pad_buttons_t'(12'($random(seed)));
		for (i = 0; i < 3; i++) begin  // Ends in the high bank
			clr_pulse(1'b0);
			read_slot(0, "six-button");
		end
		mode.six_button = 1'b0;
		for (i = 0; i < 2; i++) begin
			clr_pulse(1'b0);
			read_slot(0, "bank off");
		end
	endtask

	task automatic mouse_readout();
		int i;
		mode       = '0;
		mode.mouse = 1'b1;
		pads[0]    = pad_buttons_t'(12'($random(seed)));
		park_idle();
		send_report(8'h35, 8'hC2, 1'b1, 1'b0);
		for (i = 0; i < 4; i++) begin
			clr_pulse(1'b0);
			read_slot(0, $sformatf("mouse nibble %0d", i));
			if (i == 1)
				send_report(8'h7F, 8'h01, 1'b0, 1'b1);  // Waits for the next read
		end
		clr_pulse(1'b0);
		read_slot(0, "mouse second report");
		// Pending motion was cleared by the last latch
		for (i = 0; i < 4; i++) begin
			clr_pulse(1'b0);
			read_slot(0, "mouse after clear");
		end
	endtask

	task automatic mouse_timeout();
		park_idle();
		send_report(8'h10, 8'h20, 1'b0, 1'b0);
		clr_pulse(1'b0);
		read_slot(0, "before timeout X high");
		clr_pulse(1'b0);
		read_slot(0, "before timeout X low");
		park_idle();
		send_report(8'hE4, 8'h5A, 1'b1, 1'b1);
		repeat (4) begin
			clr_pulse(1'b0);
			read_slot(0, "after timeout");
		end
	endtask

	initial begin
		seed      = 32'hf583405b;
		errors    = 0;
		checks    = 0;
		reset     = 1'b1;
		ctrl      = '0;
		mode      = '0;
		mouse     = '0;
		exp_bank  = 1'b0;
		exp_phase = 3;
		pend_x    = 8'd0;
		pend_y    = 8'd0;
		shown_x   = 8'd0;
		shown_y   = 8'd0;
		exp_btn   = 2'b00;
		for (int i = 0; i < NUM_PADS; i++)
			pads[i] = '0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		wait_cycles(2);

		single_pad_mapping();
		multitap_scan();
		six_button_bank();
		mouse_readout();
		mouse_timeout();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb.f
hdl/pad_pkg.sv
hdl/mouse_tracker.sv
hdl/port_scan.sv
hdl/nibble_drive.sv
hdl/pad_port_top.sv
verif/pad_port_asserts.sv
verif/tb_pad_port.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the joypad port testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pad_port \
	-f tb.f \
	-o sim_tb_pad_port

./obj_dir/sim_tb_pad_port 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
